// File: include/obsRouter_defs.svh
/*
  Sizing macros for the observation router.
  OBS_NUM_SRC must be at least 2. OBS_SEL_W is derived from it
  and must not be set on its own.
*/
`ifndef OBS_ROUTER_DEFS_SVH
`define OBS_ROUTER_DEFS_SVH

// --------------------------------------------------
// Source channels
// --------------------------------------------------

// Number of source channels feeding the router.
`define OBS_NUM_SRC 6

// Width of one source channel in bits.
`define OBS_SYM_W 8

// Select width, enough to index every channel.
`define OBS_SEL_W $clog2(`OBS_NUM_SRC)

`endif

// File: design/obsPkg.sv
/*
  Shared types of the observation router.
  Sizes come from the sizing macros. Channel 0 sits at the lowest
  position of a source bundle.
*/
`include "obsRouter_defs.svh"

package obsPkg;

  // --------------------------------------------------
  // Data types
  // --------------------------------------------------

  // One channel value as seen on the debug bus.
  typedef logic [`OBS_SYM_W-1:0] symbolT;

  // A channel index. It can hold values above the channel count,
  // which the multiplexer treats as out of range.
  typedef logic [`OBS_SEL_W-1:0] selT;

  // All channels side by side, channel 0 in the low word.
  typedef symbolT [`OBS_NUM_SRC-1:0] srcBundleT;

endpackage

// File: design/muxBinStructured.sv
/*
  Binary-select multiplexer built as an explicit tree of two-input
  gates, one gate per bit and per pair, so that the path keeps its
  shape after synthesis. Purely combinational.
  An out-of-range select gives a zero output and a low outValid.
*/
`include "obsRouter_defs.svh"

module muxBinStructured (
  input  obsPkg::selT       select,
  input  obsPkg::srcBundleT in,
  output obsPkg::symbolT    out,
  output logic              outValid
);

  // --------------------------------------------------
  // Tree geometry
  // --------------------------------------------------

  // The tree has one level per select bit.
  localparam int NumSrc    = `OBS_NUM_SRC;
  localparam int SymW      = `OBS_SYM_W;
  localparam int NumLevels = `OBS_SEL_W;
  // Leaf count rounded up to a power of two.
  localparam int PadSrc    = 2 ** NumLevels;
  // Leaves plus every gate output of every level.
  localparam int NumNodes  = 2 * PadSrc - 1;

  // All tree nodes in one flat array.
  // Level 0 (the leaves) occupies the lowest PadSrc entries, each
  // following level is packed directly above the previous one,
  // and the root is the last entry.
  logic [NumNodes-1:0][SymW-1:0] node;

  // --------------------------------------------------
  // Leaves
  // --------------------------------------------------

  // Real channels fill the low leaves. The padding leaves are tied
  // to zero, so a select that points at them routes zero.
  for (genvar s = 0; s < PadSrc; s++) begin : genLeaf
    if (s < NumSrc) begin : genSrc
      assign node[s] = in[s];
    end else begin : genPad
      assign node[s] = '0;
    end
  end

  // --------------------------------------------------
  // Gate levels
  // --------------------------------------------------

  for (genvar i = 0; i < NumLevels; i++) begin : genLevel
    // Start of this level's inputs and of its outputs in node.
    localparam int InBase   = 2 * PadSrc - ((2 * PadSrc) >> i);
    localparam int OutBase  = 2 * PadSrc - ((2 * PadSrc) >> (i + 1));
    // Each level halves the number of candidates.
    localparam int NumGates = PadSrc >> (i + 1);

    for (genvar j = 0; j < NumGates; j++) begin : genGate
      for (genvar k = 0; k < SymW; k++) begin : genBit
        // Select bit i picks the odd or even member of the pair.
        assign node[OutBase + j][k] = select[i] ? node[InBase + 2 * j + 1][k]
                                                : node[InBase + 2 * j][k];
      end
    end
  end

  // The root of the tree is the routed symbol.
  assign out = node[NumNodes - 1];

  // Valid only for a select that names a real channel.
  assign outValid = (int'(select) < NumSrc);

endmodule

// File: design/obsSelectRegs.sv
/*
  Configuration block holding the observation select.
  Written through a four-phase req/ack port in the clk domain; the
  host must keep cfgSel stable while cfgReq is high.
  Any select value is stored, range checks happen downstream.
  There is no read-back path.
*/
module obsSelectRegs (
  input  logic        clk,
  input  logic        arstN,
  input  logic        cfgReq,
  input  obsPkg::selT cfgSel,
  output logic        cfgAck,
  output obsPkg::selT curSel,
  output logic        cfgWrite
);

  // --------------------------------------------------
  // Handshake decode
  // --------------------------------------------------

  // A new request is a high req that has not been acknowledged yet.
  // This is the only phase in which the select is loaded.
  logic newReq;

  // Next value of the acknowledge register.
  logic ackNext;

  assign newReq = cfgReq & ~cfgAck;

  // Ack follows the request one edge later.
  // It rises at the first edge that sees req high and falls at the
  // first edge that sees req low, which gives the four phases.
  always_comb begin
    ackNext = cfgAck;
    if (newReq) begin
      ackNext = 1'b1;
    end else if (!cfgReq) begin
      ackNext = 1'b0;
    end
  end

  // --------------------------------------------------
  // Acknowledge register
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cfgAck <= 1'b0;
    end else begin
      cfgAck <= ackNext;
    end
  end

  // --------------------------------------------------
  // Select register
  // --------------------------------------------------

  // Loaded at the same edge at which ack rises.
  // After reset channel 0 is routed.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curSel <= '0;
    end else if (newReq) begin
      curSel <= cfgSel;
    end
  end

  // --------------------------------------------------
  // Write strobe
  // --------------------------------------------------

  // High for exactly the one edge at which the select is loaded.
  // The capture stage clears its sticky error flag on it.
  assign cfgWrite = newReq;

endmodule

// File: design/obsCapture.sv
/*
  Output register stage of the observation router.
  Samples the routed symbol and its valid flag every cycle, with a
  latency of one cycle and no back-pressure.
  selError is sticky: set by a captured invalid cycle, cleared by a
  configuration write, and the clear wins.
*/
module obsCapture (
  input  logic           clk,
  input  logic           arstN,
  input  obsPkg::symbolT muxOut,
  input  logic           muxValid,
  input  logic           cfgWrite,
  output obsPkg::symbolT obsData,
  output logic           obsValid,
  output logic           selError
);

  // --------------------------------------------------
  // Data and valid
  // --------------------------------------------------

  // A new sample is taken at every edge.
  // The mux already drives zero for an invalid select, so the data
  // needs no masking here.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      obsData  <= '0;
      obsValid <= 1'b0;
    end else begin
      obsData  <= muxOut;
      obsValid <= muxValid;
    end
  end

  // --------------------------------------------------
  // Sticky select error
  // --------------------------------------------------

  // Records that some captured cycle had an out-of-range select.
  // A write clears it even when the cycle captured at that same edge
  // is invalid, so software sees a clean flag for the new select.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      selError <= 1'b0;
    end else if (cfgWrite) begin
      selError <= 1'b0;
    end else if (!muxValid) begin
      selError <= 1'b1;
    end
  end

endmodule

// File: design/obsRouter.sv
/*
  Observation router for a debug bus.
  Routes one of the source channels to a registered output, one
  cycle after the select takes effect. Single clock domain only,
  one observation port, no read-back of the select.
*/
module obsRouter (
  input  logic              clk,
  input  logic              arstN,
  input  obsPkg::srcBundleT srcData,
  input  logic              cfgReq,
  input  obsPkg::selT       cfgSel,
  output logic              cfgAck,
  output obsPkg::symbolT    obsData,
  output logic              obsValid,
  output logic              selError
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  obsPkg::selT    curSel;    // Select held by the config block.
  logic           cfgWrite;  // One-edge pulse per write.
  obsPkg::symbolT muxOut;    // Routed symbol, combinational.
  logic           muxValid;  // Select names a real channel.

  // Host-facing select register.
  obsSelectRegs selectRegs_i (
    .clk      (clk),
    .arstN    (arstN),
    .cfgReq   (cfgReq),
    .cfgSel   (cfgSel),
    .cfgAck   (cfgAck),
    .curSel   (curSel),
    .cfgWrite (cfgWrite)
  );

  // Gate-level tree steered by the stored select.
  muxBinStructured mux_i (
    .select   (curSel),
    .in       (srcData),
    .out      (muxOut),
    .outValid (muxValid)
  );

  // Registers the routed value and tracks select errors.
  obsCapture capture_i (
    .clk      (clk),
    .arstN    (arstN),
    .muxOut   (muxOut),
    .muxValid (muxValid),
    .cfgWrite (cfgWrite),
    .obsData  (obsData),
    .obsValid (obsValid),
    .selError (selError)
  );

endmodule

// File: testbench/obsRouter_chk.sv
/*
  Protocol checks bound into the observation router.
  Covers the four-phase config port, the reset values and the
  clearing of the sticky error. Data routing is left to the model.
*/
module obsRouter_chk (
  input logic clk,
  input logic arstN,
  input logic cfgReq,
  input logic cfgAck,
  input logic cfgWrite,
  input logic obsValid,
  input logic selError
);

  // --------------------------------------------------
  // Four-phase handshake
  // --------------------------------------------------

  // Ack only rises in answer to a request seen at that edge.
  ackRiseOnReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(cfgAck) |-> $past(cfgReq))
    else $error("cfgAck rose while cfgReq was low");

  // Ack only falls once the host has released the request.
  ackFallOnRelease: assert property (@(posedge clk) disable iff (!arstN)
    $fell(cfgAck) |-> !$past(cfgReq))
    else $error("cfgAck fell while cfgReq was still high");

  // --------------------------------------------------
  // Reset and sticky flag
  // --------------------------------------------------

  // Both flags stay low for as long as reset is held.
  quietInReset: assert property (@(posedge clk) !arstN |-> (!cfgAck && !obsValid))
    else $error("cfgAck or obsValid high during reset");

  // A write clears the error at the same edge, whatever was captured.
  clearOnWrite: assert property (@(posedge clk) disable iff (!arstN)
    cfgWrite |=> !selError)
    else $error("selError still set after a configuration write");

endmodule

bind obsRouter obsRouter_chk chk_i (
  .clk      (clk),
  .arstN    (arstN),
  .cfgReq   (cfgReq),
  .cfgAck   (cfgAck),
  .cfgWrite (cfgWrite),
  .obsValid (obsValid),
  .selError (selError)
);

// File: testbench/obsRouter_tb.sv
/*
  Testbench for the observation router.
  Random source data every cycle and random select writes from a
  fixed seed, checked at the falling edge against a cycle model.
  Stops at the first wrong value or handshake timeout.
*/
`include "obsRouter_defs.svh"

module obsRouter_tb;

  localparam int NumSrc     = `OBS_NUM_SRC;
  localparam int NumWrites  = 40;
  localparam int AckTimeout = 20;

  logic              clk;
  logic              arstN;
  obsPkg::srcBundleT srcData;
  logic              cfgReq;
  obsPkg::selT       cfgSel;
  logic              cfgAck;
  obsPkg::symbolT    obsData;
  logic              obsValid;
  logic              selError;

  integer seed = 32'h8f03;

  // Model state, all updated at the falling edge.
  int             modelSel;
  obsPkg::symbolT expData;
  logic           expValid;
  logic           expErr;
  logic           prevAck;
  logic           primed;   // At least one capture edge has passed since reset.

  obsRouter dut_i (
    .clk      (clk),
    .arstN    (arstN),
    .srcData  (srcData),
    .cfgReq   (cfgReq),
    .cfgSel   (cfgSel),
    .cfgAck   (cfgAck),
    .obsData  (obsData),
    .obsValid (obsValid),
    .selError (selError)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // Failure reporting and compares
  // --------------------------------------------------

  task automatic abortRun();
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkSymbol(input string name, input obsPkg::symbolT exp,
                             input obsPkg::symbolT act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %b actual %b", name, exp, act);
      abortRun();
    end
  endtask

  // --------------------------------------------------
  // Host side of the config port
  // --------------------------------------------------

  // Waits at falling edges until ack reaches the level, or gives up.
  task automatic waitAck(input logic level, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (cfgAck !== level && cycles < AckTimeout);
    if (cfgAck !== level) begin
      $display("ERROR: no %s within %0d cycles", what, AckTimeout);
      abortRun();
    end
  endtask

  // One full four-phase write; cfgSel is scrambled only after ack is low.
  task automatic writeSelect(input obsPkg::selT sel);
    @(posedge clk);
    cfgReq <= 1'b1;
    cfgSel <= sel;
    waitAck(1'b1, "ack rise after request");
    @(posedge clk);
    cfgReq <= 1'b0;
    waitAck(1'b0, "ack fall after release");
    @(posedge clk);
    cfgSel <= ~sel;
  endtask

  // --------------------------------------------------
  // Source data and reference model
  // --------------------------------------------------

  always @(posedge clk) begin : driveSources
    obsPkg::srcBundleT nextData;
    for (int c = 0; c < NumSrc; c++) begin
      nextData[c] = obsPkg::symbolT'($random(seed));
    end
    srcData <= nextData;
  end

  // Outputs at this falling edge hold what the last rising edge captured.
  always @(negedge clk) begin : model
    logic ackRose;
    if (!arstN) begin
      checkBit("cfgAck in reset", 1'b0, cfgAck);
      checkBit("obsValid in reset", 1'b0, obsValid);
      checkBit("selError in reset", 1'b0, selError);
      checkSymbol("obsData in reset", '0, obsData);
      modelSel = 0;
      expData  = '0;
      expValid = 1'b0;
      expErr   = 1'b0;
      prevAck  = 1'b0;
      primed   = 1'b0;
    end else begin
      ackRose = cfgAck && !prevAck;
      // The write clears the flag even if that edge captured an invalid cycle.
      if (primed && ackRose) begin
        expErr = 1'b0;
      end else if (primed && !expValid) begin
        expErr = 1'b1;
      end
      checkSymbol("routed obsData", expData, obsData);
      checkBit("routed obsValid", expValid, obsValid);
      checkBit("sticky selError", expErr, selError);
      // The select loads at the ack edge and routes from the next one.
      if (ackRose) begin
        modelSel = int'(cfgSel);
      end
      expValid = (modelSel < NumSrc);
      expData  = expValid ? srcData[modelSel] : '0;
      prevAck  = cfgAck;
      primed   = 1'b1;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin : mainSeq
    obsPkg::selT sel;
    int          idle;
    clk     = 1'b0;
    arstN   = 1'b0;
    srcData = '0;
    cfgReq  = 1'b0;
    cfgSel  = '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    // Channel 0 runs for a while straight out of reset.
    repeat (8) @(posedge clk);
    // Directed error then recovery, so the sticky flag is exercised.
    writeSelect(obsPkg::selT'(NumSrc));
    repeat (6) @(posedge clk);
    writeSelect(obsPkg::selT'(NumSrc - 1));
    repeat (4) @(posedge clk);
    for (int w = 0; w < NumWrites; w++) begin
      @(negedge clk);
      sel  = obsPkg::selT'($random(seed));
      idle = 2 + ($random(seed) & 7);
      writeSelect(sel);
      repeat (idle) @(posedge clk);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
design/obsPkg.sv
design/muxBinStructured.sv
design/obsSelectRegs.sv
design/obsCapture.sv
design/obsRouter.sv
testbench/obsRouter_chk.sv
testbench/obsRouter_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the observation router testbench with Verilator and runs it.
# The result is taken from the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module obsRouter_tb -o simv > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1 ; cat sim.log

grep -q "Verification failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation PASSED" && exit 0
